/* logic/fetchPkg.sv */
// ##############################
// Fetch buffer shared types
// Request, response, queue entry and the
// two decoded views of an instruction word
// ##############################

package fetchPkg;

    parameter int xlen = 32;

    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opBranch = 7'b1100011;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            epoch;
    } fetchReq;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic            epoch; // Echoed from the request
    } memRsp;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jView;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } bView;
    } instrView;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic            isJal;
        logic            isBranch;
        logic [xlen-1:0] target;
    } queueEntry;

    typedef struct packed {
        logic      valid;
        queueEntry entry;
    } decodeOut;

endpackage

/* logic/fetchControl.sv */
// ##############################
// Fetch control
// Walks the PC, spends and reclaims credits,
// and redirects on JAL or flush using an epoch bit
// ##############################

module fetchControl #(
    parameter int DEPTH = 8,
    parameter logic [fetchPkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic [fetchPkg::xlen-1:0] redirectPc,
    input  logic                      rspEpoch,
    input  logic                      rspValid,
    input  logic                      jalSeen,
    input  logic [fetchPkg::xlen-1:0] jalTarget,
    input  logic                      creditRet,
    output fetchPkg::fetchReq         req,
    output logic                      push
);

    localparam int CW = $clog2(DEPTH) + 1;

    logic [fetchPkg::xlen-1:0] pc;
    logic [fetchPkg::xlen-1:0] nextPc;
    logic [CW-1:0]             credits;
    logic                      epoch;
    logic                      epochNext;
    logic                      issue;
    logic                      drop;

    assign push  = rspValid && (rspEpoch == epoch) && !flush;
    assign drop  = rspValid && (rspEpoch != epoch) && !flush; // Wrong-path word
    assign issue = flush || (credits != '0);

    // ##############################
    // Redirect selection
    // ##############################
    always_comb begin
        epochNext = epoch;
        nextPc    = pc;
        if (flush) begin
            epochNext = ~epoch;
            nextPc    = redirectPc;
        end else if (push && jalSeen) begin
            epochNext = ~epoch;
            nextPc    = jalTarget;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            req     <= '0;
            pc      <= RESET_PC;
            epoch   <= 1'b0;
            credits <= CW'(DEPTH);
        end else begin
            epoch     <= epochNext;
            req.valid <= issue;
            req.pc    <= nextPc;
            req.epoch <= epochNext;
            pc        <= issue ? nextPc + 32'd4 : nextPc;
            if (flush) begin
                credits <= CW'(DEPTH - 1); // All credits back minus the redirected request
            end else begin
                credits <= credits - CW'(issue) + CW'(creditRet) + CW'(drop);
            end
        end
    end

endmodule

/* logic/instrPredecode.sv */
// ##############################
// Instruction predecoder
// Flags JAL and conditional branches and
// computes their targets from the returned word
// ##############################

module instrPredecode (
    input  fetchPkg::memRsp           rsp,
    output fetchPkg::queueEntry       entry,
    output logic                      jalSeen,
    output logic [fetchPkg::xlen-1:0] jalTarget
);

    fetchPkg::instrView        view;
    logic [fetchPkg::xlen-1:0] jImm;
    logic [fetchPkg::xlen-1:0] bImm;
    logic                      isJal;
    logic                      isBranch;

    assign view.raw = rsp.instr;

    // ##############################
    // Immediate reassembly
    // ##############################
    assign jImm = {{11{view.jView.imm20}}, view.jView.imm20, view.jView.imm19_12,
                   view.jView.imm11, view.jView.imm10_1, 1'b0};

    assign bImm = {{19{view.bView.imm12}}, view.bView.imm12, view.bView.imm11,
                   view.bView.imm10_5, view.bView.imm4_1, 1'b0};

    assign isJal    = (view.jView.opcode == fetchPkg::opJal);
    assign isBranch = (view.bView.opcode == fetchPkg::opBranch);

    assign jalTarget = rsp.pc + jImm;
    assign jalSeen   = rsp.valid && isJal;

    always_comb begin
        entry.pc       = rsp.pc;
        entry.instr    = rsp.instr;
        entry.isJal    = isJal;
        entry.isBranch = isBranch;
        if (isJal) begin
            entry.target = jalTarget;
        end else if (isBranch) begin
            entry.target = rsp.pc + bImm; // Taken target only
        end else begin
            entry.target = rsp.pc + 32'd4;
        end
    end

endmodule

/* logic/fetchQueue.sv */
// ##############################
// Fetch queue
// Circular buffer between fetch and decode
// with a registered dequeue and credit return
// ##############################

module fetchQueue #(
    parameter int DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                push,
    input  fetchPkg::queueEntry entry,
    input  logic                take,
    output fetchPkg::decodeOut  out,
    output logic                creditRet
);

    localparam int PW = $clog2(DEPTH);

    fetchPkg::queueEntry mem [DEPTH];
    fetchPkg::queueEntry outEntry;
    logic [PW-1:0]       head;
    logic [PW-1:0]       tail;
    logic [PW:0]         count;
    logic                outValid;
    logic                doPush;
    logic                doTake;

    assign doPush    = push && !flush;
    assign doTake    = take && (count != '0) && !flush;
    assign creditRet = doTake; // One credit per word handed to decode

    assign out = {outValid, outEntry};

    // ##############################
    // Pointers and occupancy
    // ##############################
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            outValid <= 1'b0;
        end else if (flush) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= doTake;
            if (doPush) begin
                tail <= tail + 1'b1; // Wraps at DEPTH
            end
            if (doTake) begin
                head <= head + 1'b1;
            end
            case ({doPush, doTake})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ##############################
    // Storage and output register
    // ##############################
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[tail] <= entry;
        end
        if (doTake) begin
            outEntry <= mem[head];
        end
    end

endmodule

/* logic/fetchUnit.sv */
// ##############################
// Fetch unit top level
// Control, predecoder and queue between
// instruction memory and decode
// ##############################

module fetchUnit #(
    parameter int DEPTH = 8,
    parameter logic [fetchPkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic [fetchPkg::xlen-1:0] redirectPc,
    input  fetchPkg::memRsp           rsp,
    input  logic                      take,
    output fetchPkg::fetchReq         req,
    output fetchPkg::decodeOut        out
);

    fetchPkg::queueEntry       entry;
    logic [fetchPkg::xlen-1:0] jalTarget;
    logic                      jalSeen;
    logic                      push;
    logic                      creditRet;

    fetchControl #(
        .DEPTH    (DEPTH),
        .RESET_PC (RESET_PC)
    ) i_fetchControl (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .redirectPc (redirectPc),
        .rspEpoch   (rsp.epoch),
        .rspValid   (rsp.valid),
        .jalSeen    (jalSeen),
        .jalTarget  (jalTarget),
        .creditRet  (creditRet),
        .req        (req),
        .push       (push)
    );

    instrPredecode i_instrPredecode (
        .rsp       (rsp),
        .entry     (entry),
        .jalSeen   (jalSeen),
        .jalTarget (jalTarget)
    );

    fetchQueue #(
        .DEPTH (DEPTH)
    ) i_fetchQueue (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .push      (push),
        .entry     (entry),
        .take      (take),
        .out       (out),
        .creditRet (creditRet)
    );

endmodule

/* sim/fetchUnitTable.svh */
// ##############################
// Fetch unit test tables
// Program words and the scenario rows
// ##############################

`ifndef FETCH_UNIT_TABLE_SVH
`define FETCH_UNIT_TABLE_SVH

// Words that differ from the fill pattern
localparam int progLen = 5;

localparam logic [31:0] progAddr [progLen] = '{
    32'h0000_0010,  // JAL +0x30
    32'h0000_0044,  // BEQ +8
    32'h0000_0048,  // BEQ -4
    32'h0000_0104,  // BNE +16
    32'h0000_0208   // JAL -8, loops back to 0x200
};

localparam logic [31:0] progWord [progLen] = '{
    32'h0300_006F,
    32'h0000_0463,
    32'hFE00_0EE3,
    32'h0020_9863,
    32'hFF9F_F06F
};

typedef struct packed {
    logic        doFlush;     // Flush to startPc right after reset
    logic [31:0] startPc;
    int          nWords;      // Entries to receive
    int          mode;        // 0 always take, 1 hold then take, 2 random
    int          holdCycles;
    int          flushAfter;  // Flush after this many entries, 0 for none
    logic [31:0] flushPc;
    logic        checkCredit;
} scenarioRow;

localparam int numScen = 5;

localparam scenarioRow scenarios [numScen] = '{
    '{1'b0, 32'h0000_0000, 12, 0,  0, 0, 32'h0000_0000, 1'b0},
    '{1'b1, 32'h0000_0100, 20, 1, 30, 0, 32'h0000_0000, 1'b1},
    '{1'b0, 32'h0000_0000, 14, 0,  0, 6, 32'h0000_0200, 1'b0},
    '{1'b0, 32'h0000_0000, 40, 2,  0, 0, 32'h0000_0000, 1'b0},
    '{1'b1, 32'h0000_0208,  8, 2,  0, 0, 32'h0000_0000, 1'b0}
};

function automatic string scenName(int idx);
    case (idx)
        0:       return "straight";
        1:       return "holdTake";
        2:       return "midFlush";
        3:       return "randomTake";
        default: return "jalLoop";
    endcase
endfunction

`endif

/* sim/fetchUnitTb.sv */
// ##############################
// Fetch unit testbench
// Memory model, reference walk of the program,
// take patterns, flushes and timeout
// ##############################

module fetchUnitTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 8;

    `include "fetchUnitTable.svh"

    logic                      clk;
    logic                      reset;
    logic                      flush;
    logic [fetchPkg::xlen-1:0] redirectPc;
    fetchPkg::memRsp           rsp;
    logic                      take;
    fetchPkg::fetchReq         req;
    fetchPkg::decodeOut        out;
    int                        cycles;
    int                        limit;

    fetchUnit #(
        .DEPTH    (DEPTH),
        .RESET_PC ('0)
    ) i_fetchUnit (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .redirectPc (redirectPc),
        .rsp        (rsp),
        .take       (take),
        .req        (req),
        .out        (out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("sim failed");
            $fatal(1, "timeout after %0d cycles without finishing the tests", cycles);
        end
    end

    // ##############################
    // Reference model
    // ##############################
    function automatic logic [31:0] wordAt(logic [31:0] addr);
        for (int i = 0; i < progLen; i++) begin
            if (progAddr[i] == addr) return progWord[i];
        end
        return {addr[31:7] ^ addr[24:0], 7'h13}; // addi fill
    endfunction

    function automatic logic [31:0] jOffset(logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] bOffset(logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic fetchPkg::queueEntry expectedEntry(logic [31:0] pc);
        fetchPkg::queueEntry e;
        e.pc       = pc;
        e.instr    = wordAt(pc);
        e.isJal    = (e.instr[6:0] == 7'b1101111);
        e.isBranch = (e.instr[6:0] == 7'b1100011);
        if (e.isJal) e.target = pc + jOffset(e.instr);
        else if (e.isBranch) e.target = pc + bOffset(e.instr);
        else e.target = pc + 32'd4;
        return e;
    endfunction

    // ##############################
    // Checks
    // ##############################
    task automatic checkEntry(string name, fetchPkg::queueEntry exp, fetchPkg::queueEntry act);
        if (exp !== act) begin
            $display("mismatch %s entry exp %h act %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic checkReq(string name, fetchPkg::fetchReq exp, fetchPkg::fetchReq act);
        if (exp !== act) begin
            $display("mismatch %s req exp %h act %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("mismatch %s out.valid exp %b act %b", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic checkCount(string name, int exp, int act);
        if (exp != act) begin
            $display("mismatch %s outstanding requests exp %0d act %0d", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // One cycle, memory answers the request of the last edge
    task automatic tick();
        @(negedge clk);
        rsp = {req.valid, req.pc, wordAt(req.pc), req.epoch};
    endtask

    task automatic applyFlush(string name, logic [31:0] pc);
        logic prevEpoch;
        prevEpoch  = req.epoch;
        take       = 1'b1; // Output must stay idle anyway
        flush      = 1'b1;
        redirectPc = pc;
        tick();
        flush = 1'b0;
        checkReq(name, {1'b1, pc, ~prevEpoch}, req);
        checkBit(name, 1'b0, out.valid);
    endtask

    task automatic runScenario(int s);
        scenarioRow          row;
        string               name;
        logic [31:0]         expPc;
        fetchPkg::queueEntry expEntry;
        int                  got;
        int                  c;
        int                  issued;
        int                  taken;
        row  = scenarios[s];
        name = scenName(s);
        reset = 1'b0;
        take  = 1'b0;
        flush = 1'b0;
        repeat (5) begin
            tick();
            checkReq(name, '0, req);
            checkBit(name, 1'b0, out.valid);
        end
        reset = 1'b1;
        expPc = '0;
        got = 0;
        c = 0;
        issued = 0;
        taken = 0;
        if (row.doFlush) begin
            tick();
            tick();
            applyFlush(name, row.startPc);
            expPc  = row.startPc;
            issued = 1;
        end
        while (got < row.nWords) begin
            case (row.mode)
                0:       take = 1'b1;
                1:       take = (c >= row.holdCycles);
                default: take = ($urandom % 3) != 0;
            endcase
            tick();
            c++;
            if (req.valid) issued++;
            if (row.checkCredit && c == row.holdCycles) begin
                checkCount(name, DEPTH, issued - taken); // Credits used up while held
            end
            if (out.valid) begin
                expEntry = expectedEntry(expPc);
                checkEntry(name, expEntry, out.entry);
                expPc = expEntry.isJal ? expEntry.target : expPc + 32'd4; // Branches only flagged
                got++;
                taken++;
                if (got == row.flushAfter) begin
                    applyFlush(name, row.flushPc);
                    expPc  = row.flushPc;
                    issued = 1;
                    taken  = 0;
                end
            end
            if (row.checkCredit && (issued - taken > DEPTH)) begin
                $display("sim failed");
                $fatal(1, "%s issued %0d requests beyond taken words, more than the queue depth",
                       name, issued - taken);
            end
        end
        take = 1'b0;
    endtask

    initial begin
        int total;
        clk        = 1'b0;
        reset      = 1'b0;
        flush      = 1'b0;
        take       = 1'b0;
        redirectPc = '0;
        rsp        = '0;
        cycles     = 0;
        total      = 0;
        void'($urandom(32'h7cb14809));
        for (int s = 0; s < numScen; s++) begin
            total += scenarios[s].nWords + scenarios[s].holdCycles;
        end
        limit = 4 * total + 100;
        for (int s = 0; s < numScen; s++) begin
            runScenario(s);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+sim
logic/fetchPkg.sv
logic/fetchControl.sv
logic/instrPredecode.sv
logic/fetchQueue.sv
logic/fetchUnit.sv
sim/fetchUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0
TOP       := fetchUnitTb
FLIST     := flist.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FLIST)) sim/fetchUnitTable.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
